/* all.f */
logic/cache_biu_pkg.sv
logic/biu_sequencer.sv
logic/transfer_counter.sv
logic/line_buffer.sv
logic/bus_request_driver.sv
logic/cache_biu_ctrl.sv
bench/biu_memory_model.sv
bench/tb_cache_biu_ctrl.sv

/* bench/biu_memory_model.sv */
/*
 * behavioral bus slave, one transfer at a time
 * stb_ack comes delay_i+1 cycles after the strobe is seen, then one beat
 * per cycle in wrap order from the requested word
 * write data is logged, word 0 at stb_ack and the rest on d_ack
 */

`timescale 1ns/1ps
`default_nettype none

module biu_memory_model (
  input  wire                      clk_i,
  input  wire                      rst_ni,
  input  cache_biu_pkg::biu_req_t  req_i,
  input  wire [2:0]                delay_i,     // extra strobe wait cycles
  input  wire [2:0]                err_beat_i,  // beat answered with err, 0 for none
  output cache_biu_pkg::biu_rsp_t  rsp_o
);

  logic [1:0]  phase;     // 0 idle, 1 strobe wait, 2 beats
  logic [2:0]  wait_cnt;
  logic [1:0]  beat;
  logic [1:0]  last;      // index of the final beat
  logic [31:0] base;
  logic        we;
  logic [31:0] beat_adr;
  logic [31:0] log_word [4];  // write-back log
  logic [31:0] log_adr;
  int          log_cnt;

  // memory content, a function of the word address
  function automatic logic [31:0] mem_word(input logic [31:0] a);
    return ({a[31:2], 2'b00} * 32'h9e3779b1) ^ 32'h3c5a0f17;
  endfunction

  assign beat_adr = {base[31:4], base[3:2] + beat, 2'b00};  // wrap inside the line

  always_ff @(posedge clk_i or negedge rst_ni)
  begin
    if (!rst_ni)
    begin
      phase   <= 2'd0;
      rsp_o   <= '0;
      log_cnt <= 0;
    end
    else
    begin
      rsp_o.stb_ack <= 1'b0;
      rsp_o.ack     <= 1'b0;
      rsp_o.d_ack   <= 1'b0;
      rsp_o.err     <= 1'b0;
      if (((rsp_o.stb_ack && we) || rsp_o.d_ack) && log_cnt < 4)
      begin
        log_word[log_cnt] <= req_i.d;   // word taken this cycle
        log_cnt           <= log_cnt + 1;
      end
      case (phase)
        2'd0:
          if (req_i.stb)
          begin
            base     <= req_i.adr;
            we       <= req_i.we;
            last     <= (req_i.btype == cache_biu_pkg::WRAP4) ? 2'd3 : 2'd0;
            wait_cnt <= delay_i;
            phase    <= 2'd1;
            if (req_i.we)
            begin
              log_cnt <= 0;             // new write-back
              log_adr <= req_i.adr;
            end
          end
        2'd1:
          if (wait_cnt == 3'd0)
          begin
            rsp_o.stb_ack <= 1'b1;
            beat          <= 2'd0;
            phase         <= 2'd2;
          end
          else
            wait_cnt <= wait_cnt - 3'd1;
        default:
        begin
          rsp_o.adro <= beat_adr;
          rsp_o.q    <= we ? '0 : mem_word(beat_adr);
          if (err_beat_i == 3'(beat) + 3'd1)
          begin
            rsp_o.err <= 1'b1;          // burst ends here
            phase     <= 2'd0;
          end
          else
          begin
            rsp_o.ack   <= 1'b1;
            rsp_o.d_ack <= we && (beat != 2'd0);  // word 0 left with the strobe
            if (beat == last)
              phase <= 2'd0;
          end
          beat <= beat + 2'd1;
        end
      endcase
    end
  end

endmodule

`default_nettype wire

/* bench/tb_cache_biu_ctrl.sv */
/*
 * testbench for the cache bus interface controller
 * line reads with and without a store, write-back, non-cacheable read,
 * flush during a fill and an err ending a fill
 * the err case runs last since it leaves beats counted in flight
 */

`timescale 1ns/1ps
`default_nettype none

module tb_cache_biu_ctrl;

  localparam int TXN_COUNT   = 8;
  localparam int CYCLE_LIMIT = 40 * TXN_COUNT;

  logic                         clk;
  logic                         rst_n;
  cache_biu_pkg::biu_cmd_e      biucmd;
  logic                         nc_req;
  logic                         flush;
  cache_biu_pkg::cpu_req_t      cpu;
  logic [31:0]                  evict_adr;
  logic [127:0]                 evict_line;
  logic [2:0]                   mem_delay;
  logic [2:0]                   err_beat;
  cache_biu_pkg::biu_rsp_t      rsp;
  cache_biu_pkg::biu_req_t      req;
  logic                         cmd_ack;
  logic                         busy;
  logic                         nc_ack;
  logic [2:0]                   inflight;
  logic [127:0]                 line;
  logic                         dirty;
  logic [31:0]                  seed;
  int                           cycles    = 0;
  logic                         busy_exp  = 1'b0;  // reference busy flag
  logic                         ack_prev  = 1'b0;
  logic                         stb_track = 1'b0;  // strobe waiting for stb_ack
  logic [31:0]                  held_adr;
  logic                         held_we;
  logic [31:0]                  held_d;

  cache_biu_ctrl u_dut (
    .clk_i (clk), .rst_ni (rst_n), .biucmd_i (biucmd), .noncacheable_req_i (nc_req),
    .flush_i (flush), .cpu_i (cpu), .evict_adr_i (evict_adr),
    .evict_line_i (evict_line), .biu_rsp_i (rsp), .biucmd_ack_o (cmd_ack),
    .biucmd_busy_o (busy), .noncacheable_ack_o (nc_ack), .inflight_cnt_o (inflight),
    .biu_line_o (line), .biu_line_dirty_o (dirty), .biu_req_o (req)
  );

  biu_memory_model u_mem (
    .clk_i (clk), .rst_ni (rst_n), .req_i (req), .delay_i (mem_delay),
    .err_beat_i (err_beat), .rsp_o (rsp)
  );

  initial
  begin
    clk = 1'b0;
    forever #50 clk = ~clk;
  end

  function automatic logic [31:0] next_rand();
    seed = seed * 32'd1664525 + 32'd1013904223;  // lcg step
    return seed;
  endfunction

  function automatic logic [31:0] mem_word(input logic [31:0] a);
    return ({a[31:2], 2'b00} * 32'h9e3779b1) ^ 32'h3c5a0f17;
  endfunction

  // pending cpu access with req set
  function automatic cache_biu_pkg::cpu_req_t cpu_access(input logic [31:0] adr,
                                                         input logic        we,
                                                         input logic [3:0]  be,
                                                         input logic [31:0] d);
    cache_biu_pkg::cpu_req_t c;
    c.req = 1'b1;
    c.adr = adr;
    c.we  = we;
    c.be  = be;
    c.d   = d;
    return c;
  endfunction

  // line in slot order with the store bytes merged into their word
  function automatic logic [127:0] expect_line(input logic [31:0] adr, input logic st,
                                               input logic [3:0] be, input logic [31:0] d);
    logic [127:0] l;
    logic [31:0]  w;
    for (int s = 0; s < 4; s++)
    begin
      w = mem_word({adr[31:4], 2'(s), 2'b00});
      if (st && adr[3:2] == 2'(s))
        for (int b = 0; b < 4; b++)
          if (be[b])
            w[b*8 +: 8] = d[b*8 +: 8];
      l[s*32 +: 32] = w;
    end
    return l;
  endfunction

  task automatic compare(input string name, input logic [127:0] got, input logic [127:0] exp);
    if (got !== exp)
    begin
      $display("[ERROR] %0t %s got %0h expected %0h", $time, name, got, exp);
      $display("*** TEST FAILED ***");
      $fatal(1, "mismatch on %s", name);
    end
  endtask

  // line command until biucmd_ack_o with an optional flush after stb_ack
  task automatic line_command(input cache_biu_pkg::biu_cmd_e cmd, input logic do_flush,
                              input logic check_data, input logic [127:0] exp_line,
                              input logic exp_dirty, input logic exp_err);
    @(posedge clk);
    biucmd    <= cmd;
    mem_delay <= 3'(next_rand() % 5);
    do
    begin
      @(posedge clk);
      flush      <= do_flush && rsp.stb_ack;   // one cycle pulse
      evict_adr  <= ~evict_adr;                // only sampled in IDLE
      evict_line <= ~evict_line;
      if (do_flush && rsp.ack)
        compare("noncacheable_ack_o", nc_ack, 1'b0);  // owed beat swallowed
    end
    while (!cmd_ack);
    compare("biu_rsp.err", rsp.err, exp_err);
    if (check_data)
    begin
      compare("biu_line_o", line, exp_line);
      compare("biu_line_dirty_o", dirty, exp_dirty);
    end
    biucmd <= cache_biu_pkg::NOP;
  endtask

  task automatic noncacheable_read(input logic [31:0] adr);
    @(posedge clk);
    cpu    <= cpu_access(adr, 1'b0, 4'hf, '0);
    nc_req <= 1'b1;
    @(posedge clk);
    compare("biu_req_o.stb", req.stb, 1'b1);
    compare("biu_req_o.btype", req.btype, cache_biu_pkg::INCR);
    compare("biu_req_o.size", req.size, cache_biu_pkg::WORD);   // be all ones
    compare("biu_req_o.adr", req.adr, adr);
    compare("biu_req_o.we", req.we, 1'b0);
    while (!rsp.stb_ack)
      @(posedge clk);
    nc_req <= 1'b0;
    do
      @(posedge clk);
    while (!rsp.ack);
    compare("noncacheable_ack_o", nc_ack, 1'b1);
    compare("biu_rsp.q", rsp.q, mem_word(adr));
    @(posedge clk);
    compare("inflight_cnt_o", inflight, 3'd0);
  endtask

  //////////////////////////////////////////////////////////////////////
  // per cycle checks and the timeout
  always @(posedge clk)
  begin
    cycles++;
    if (cycles > CYCLE_LIMIT)
    begin
      $display("timeout: run did not finish within %0d cycles", CYCLE_LIMIT);
      $display("*** TEST FAILED ***");
      $fatal(1, "timeout");
    end
    if (rst_n)
    begin
      compare("biucmd_busy_o", busy, busy_exp);
      if (ack_prev)
        compare("biucmd_ack_o", cmd_ack, 1'b0);
      ack_prev = cmd_ack;
      if (cmd_ack)
        busy_exp = 1'b0;
      else if (biucmd != cache_biu_pkg::NOP)
        busy_exp = 1'b1;
      if (req.stb && stb_track)
      begin
        compare("biu_req_o.adr", req.adr, held_adr);
        compare("biu_req_o.we", req.we, held_we);
        compare("biu_req_o.d", req.d, held_d);
      end
      stb_track = req.stb && !rsp.stb_ack;
      held_adr  = req.adr;
      held_we   = req.we;
      held_d    = req.d;
    end
  end

  //////////////////////////////////////////////////////////////////////
  // stimulus
  initial
  begin
    logic [31:0]  a;
    logic [31:0]  d;
    logic [3:0]   be;
    logic [127:0] el;
    seed       = 32'h229a8c17;
    rst_n      = 1'b0;
    biucmd     = cache_biu_pkg::NOP;
    nc_req     = 1'b0;
    flush      = 1'b0;
    cpu        = '0;
    evict_adr  = '0;
    evict_line = '0;
    mem_delay  = '0;
    err_beat   = '0;
    repeat (16) @(posedge clk);
    rst_n <= 1'b1;

    repeat (2)
    begin                                      // plain fills
      a = next_rand();
      cpu <= cpu_access(a, 1'b0, 4'hf, '0);
      line_command(cache_biu_pkg::READWAY, 1'b0, 1'b1, expect_line(a, 1'b0, 4'h0, '0),
                   1'b0, 1'b0);
    end

    a  = next_rand();                          // fill with a pending store
    d  = next_rand();
    be = 4'(next_rand()) | 4'h1;
    cpu <= cpu_access(a, 1'b1, be, d);
    line_command(cache_biu_pkg::READWAY, 1'b0, 1'b1, expect_line(a, 1'b1, be, d),
                 1'b1, 1'b0);

    a  = next_rand() & 32'hffff_fff0;          // write-back of a whole line
    el = {next_rand(), next_rand(), next_rand(), next_rand()};
    cpu        <= '0;
    evict_adr  <= a;
    evict_line <= el;
    line_command(cache_biu_pkg::WRITEWAY, 1'b0, 1'b0, '0, 1'b0, 1'b0);
    @(posedge clk);
    compare("log count", u_mem.log_cnt, 4);
    compare("log address", u_mem.log_adr, a);
    for (int i = 0; i < 4; i++)
      compare("log word", u_mem.log_word[i], el[i*32 +: 32]);

    noncacheable_read(next_rand());

    a = next_rand();                           // flush during a fill
    cpu <= cpu_access(a, 1'b0, 4'hf, '0);
    line_command(cache_biu_pkg::READWAY, 1'b1, 1'b1, expect_line(a, 1'b0, 4'h0, '0),
                 1'b0, 1'b0);
    noncacheable_read(next_rand());

    err_beat <= 3'd2;                          // err on the second beat
    line_command(cache_biu_pkg::READWAY, 1'b0, 1'b0, '0, 1'b0, 1'b1);
    err_beat <= 3'd0;
    repeat (2) @(posedge clk);

    $display("*** TEST PASSED ***");
    $finish;
  end

endmodule

`default_nettype wire

/* logic/biu_sequencer.sv */
/*
 * bus interface state machine for line commands
 * a command is only taken in IDLE, non-cacheable traffic only runs there
 * the command input must stay stable until biucmd_ack_o
 * an err on any beat ends the burst at once
 */

`timescale 1ns/1ps
`default_nettype none

module biu_sequencer (
  input  wire                       clk_i,
  input  wire                       rst_ni,
  input  cache_biu_pkg::biu_cmd_e   biucmd_i,
  input  wire                       stb_ack_i,   // bus took the strobe
  input  wire                       ack_i,
  input  wire                       err_i,
  input  wire                       last_beat_i, // beat counter at zero
  output cache_biu_pkg::biu_state_e state_o,
  output logic                      biucmd_ack_o,
  output logic                      biucmd_busy_o
);

  cache_biu_pkg::biu_state_e state_q, state_d;
  logic                      line_cmd;   // READWAY or WRITEWAY pending
  logic                      burst_end;  // last ack or any err
  logic                      busy_d;

  assign line_cmd  = (biucmd_i == cache_biu_pkg::READWAY) ||
                     (biucmd_i == cache_biu_pkg::WRITEWAY);
  assign burst_end = (ack_i & last_beat_i) | err_i;

  //////////////////////////////////////////////////////////////////////
  // next state
  always_comb
  begin
    state_d = state_q;
    busy_d  = biucmd_busy_o;
    case (state_q)
      cache_biu_pkg::IDLE:
        if (line_cmd)
        begin
          busy_d  = 1'b1;
          // strobe goes out this cycle, skip the wait if taken at once
          state_d = stb_ack_i ? cache_biu_pkg::BURST : cache_biu_pkg::WAIT4BIU;
        end
      cache_biu_pkg::WAIT4BIU:
        if (stb_ack_i)
        begin
          state_d = cache_biu_pkg::BURST;
        end
      cache_biu_pkg::BURST:
        if (burst_end)
        begin
          state_d = cache_biu_pkg::IDLE;
          busy_d  = 1'b0;          // drops the cycle after the command ack
        end
      default:
        state_d = cache_biu_pkg::IDLE;
    endcase
  end

  always_ff @(posedge clk_i or negedge rst_ni)
  begin
    if (!rst_ni)
    begin
      state_q       <= cache_biu_pkg::IDLE;
      biucmd_busy_o <= 1'b0;
    end
    else
    begin
      state_q       <= state_d;
      biucmd_busy_o <= busy_d;
    end
  end

  assign state_o = state_q;

  // one-cycle end of command, line is valid now
  assign biucmd_ack_o = (state_q == cache_biu_pkg::BURST) & burst_end;

endmodule

`default_nettype wire

/* logic/bus_request_driver.sv */
/*
 * combinational bus request per sequencer state
 * adr, we and d are captured in every IDLE cycle and replayed while
 * the strobe waits for stb_ack, so they cannot change in that window
 */

`timescale 1ns/1ps
`default_nettype none

module bus_request_driver (
  input  wire                                 clk_i,
  input  cache_biu_pkg::biu_state_e           state_i,
  input  cache_biu_pkg::biu_cmd_e             biucmd_i,
  input  wire                                 noncacheable_req_i,
  input  cache_biu_pkg::cpu_req_t             cpu_i,
  input  wire [cache_biu_pkg::PLEN-1:0]       evict_adr_i,
  input  wire [cache_biu_pkg::LINE_BITS-1:0]  evict_line_i,
  input  wire [cache_biu_pkg::XLEN-1:0]       tx_word_i,   // write-back word in flight
  output cache_biu_pkg::biu_req_t             req_o
);

  logic [cache_biu_pkg::PLEN-1:0] adr_hold;
  logic                           we_hold;
  logic [cache_biu_pkg::XLEN-1:0] d_hold;

  // transfer size from the byte lanes in use
  function automatic cache_biu_pkg::xfer_size_e be2size(
    input logic [cache_biu_pkg::XLEN/8-1:0] be
  );
    cache_biu_pkg::xfer_size_e size;
    case (be)
      4'b1111:          size = cache_biu_pkg::WORD;
      4'b0011, 4'b1100: size = cache_biu_pkg::HWORD;
      default:          size = cache_biu_pkg::BYTE;
    endcase
    return size;
  endfunction

  always_comb
  begin
    req_o.stb   = 1'b0;
    req_o.adr   = adr_hold;
    req_o.we    = we_hold;
    req_o.d     = d_hold;
    req_o.size  = cache_biu_pkg::WORD;   // line traffic is word wide
    req_o.btype = cache_biu_pkg::WRAP4;
    case (state_i)
      cache_biu_pkg::IDLE:
        case (biucmd_i)
          cache_biu_pkg::READWAY:
          begin
            req_o.stb = 1'b1;
            req_o.adr = {cpu_i.adr[cache_biu_pkg::PLEN-1:cache_biu_pkg::WORD_LSB],
                         {cache_biu_pkg::WORD_LSB{1'b0}}};
            req_o.we  = 1'b0;
            req_o.d   = '0;
          end
          cache_biu_pkg::WRITEWAY:
          begin
            req_o.stb = 1'b1;
            req_o.adr = evict_adr_i;
            req_o.we  = 1'b1;
            req_o.d   = evict_line_i[cache_biu_pkg::XLEN-1:0];
          end
          default:
          begin                          // non-cacheable pass-through
            req_o.stb   = noncacheable_req_i;
            req_o.adr   = cpu_i.adr;
            req_o.we    = cpu_i.we;
            req_o.d     = cpu_i.d;
            req_o.size  = be2size(cpu_i.be);
            req_o.btype = cache_biu_pkg::INCR;
          end
        endcase
      cache_biu_pkg::WAIT4BIU: req_o.stb = 1'b1;    // stretched strobe, held fields
      cache_biu_pkg::BURST:    req_o.d   = tx_word_i;
      default: ;
    endcase
  end

  // hold copy for the stretched strobe
  always_ff @(posedge clk_i)
  begin
    if (state_i == cache_biu_pkg::IDLE)
    begin
      adr_hold <= req_o.adr;
      we_hold  <= req_o.we;
      d_hold   <= req_o.d;
    end
  end

endmodule

`default_nettype wire

/* logic/cache_biu_ctrl.sv */
/*
 * cache bus interface controller top
 * line fills and write-backs as wrap-4 bursts, non-cacheable singles
 * only while idle; acks owed from before a flush are not passed on
 */

`timescale 1ns/1ps
`default_nettype none

module cache_biu_ctrl (
  input  wire                                      clk_i,
  input  wire                                      rst_ni,
  input  cache_biu_pkg::biu_cmd_e                  biucmd_i,
  input  wire                                      noncacheable_req_i,
  input  wire                                      flush_i,
  input  cache_biu_pkg::cpu_req_t                  cpu_i,
  input  wire [cache_biu_pkg::PLEN-1:0]            evict_adr_i,
  input  wire [cache_biu_pkg::LINE_BITS-1:0]       evict_line_i,
  input  cache_biu_pkg::biu_rsp_t                  biu_rsp_i,
  output logic                                     biucmd_ack_o,
  output logic                                     biucmd_busy_o,
  output logic                                     noncacheable_ack_o,
  output logic [cache_biu_pkg::INFLIGHT_BITS-1:0]  inflight_cnt_o,
  output logic [cache_biu_pkg::LINE_BITS-1:0]      biu_line_o,
  output logic                                     biu_line_dirty_o,
  output cache_biu_pkg::biu_req_t                  biu_req_o
);

  cache_biu_pkg::biu_state_e      state;
  logic                           last_beat;
  logic                           discard_active;  // old acks still arriving
  logic [cache_biu_pkg::XLEN-1:0] tx_word;

  //////////////////////////////////////////////////////////////////////
  // control
  biu_sequencer u_sequencer (
    .clk_i         (clk_i),
    .rst_ni        (rst_ni),
    .biucmd_i      (biucmd_i),
    .stb_ack_i     (biu_rsp_i.stb_ack),
    .ack_i         (biu_rsp_i.ack),
    .err_i         (biu_rsp_i.err),
    .last_beat_i   (last_beat),
    .state_o       (state),
    .biucmd_ack_o  (biucmd_ack_o),
    .biucmd_busy_o (biucmd_busy_o)
  );

  transfer_counter u_counter (
    .clk_i            (clk_i),
    .rst_ni           (rst_ni),
    .state_i          (state),
    .rsp_i            (biu_rsp_i),
    .btype_i          (biu_req_o.btype),  // sizes the accepted strobe
    .flush_i          (flush_i),
    .last_beat_o      (last_beat),
    .inflight_cnt_o   (inflight_cnt_o),
    .discard_active_o (discard_active)
  );

  //////////////////////////////////////////////////////////////////////
  // data path
  line_buffer u_line_buffer (
    .clk_i        (clk_i),
    .state_i      (state),
    .biucmd_i     (biucmd_i),
    .cpu_i        (cpu_i),
    .evict_line_i (evict_line_i),
    .rsp_i        (biu_rsp_i),
    .line_o       (biu_line_o),
    .line_dirty_o (biu_line_dirty_o),
    .tx_word_o    (tx_word)
  );

  bus_request_driver u_req_driver (
    .clk_i              (clk_i),
    .state_i            (state),
    .biucmd_i           (biucmd_i),
    .noncacheable_req_i (noncacheable_req_i),
    .cpu_i              (cpu_i),
    .evict_adr_i        (evict_adr_i),
    .evict_line_i       (evict_line_i),
    .tx_word_i          (tx_word),
    .req_o              (biu_req_o)
  );

  // no ack for transfers dropped by a flush
  assign noncacheable_ack_o = biu_rsp_i.ack & ~flush_i & ~discard_active;

endmodule

`default_nettype wire

/* logic/cache_biu_pkg.sv */
/*
 * shared widths, encodings and bundles for the cache bus interface
 * sizes are fixed: 32-bit bus words, 32-bit physical addresses,
 * 128-bit cache lines filled and drained as wrap-4 bursts
 * transfer sizes above one word are not supported
 */

`default_nettype none

package cache_biu_pkg;

  //////////////////////////////////////////////////////////////////////
  // widths
  localparam int XLEN          = 32;               // bus word
  localparam int PLEN          = 32;               // physical address
  localparam int LINE_BITS     = 128;              // one cache line
  localparam int BURST_LEN     = LINE_BITS / XLEN; // beats per line
  localparam int BEAT_BITS     = 2;                // beat index / counter
  localparam int WORD_LSB      = 2;                // byte offset bits in a word
  localparam int INFLIGHT_BITS = 3;                // in-flight and discard counters

  // beats added to the in-flight count by one accepted wrap-4 strobe
  localparam logic [INFLIGHT_BITS-1:0] BURST_BEATS = INFLIGHT_BITS'(BURST_LEN);

  //////////////////////////////////////////////////////////////////////
  // encodings
  typedef enum logic [1:0] {
    NOP,       // no line command, non-cacheable traffic allowed
    READWAY,   // fill a line from memory
    WRITEWAY   // write an evicted line back
  } biu_cmd_e;

  typedef enum logic [1:0] {
    IDLE,
    WAIT4BIU,  // strobe stretched until stb_ack
    BURST
  } biu_state_e;

  typedef enum logic [1:0] {
    SINGLE,
    INCR,
    WRAP4
  } burst_type_e;

  typedef enum logic [1:0] {
    BYTE,
    HWORD,
    WORD
  } xfer_size_e;

  //////////////////////////////////////////////////////////////////////
  // bundles
  typedef struct packed {
    logic              req;
    logic [PLEN-1:0]   adr;
    logic              we;
    logic [XLEN/8-1:0] be;
    logic [XLEN-1:0]   d;
  } cpu_req_t;

  typedef struct packed {
    logic              stb;
    logic [PLEN-1:0]   adr;
    logic              we;
    logic [XLEN-1:0]   d;
    xfer_size_e        size;
    burst_type_e       btype;
  } biu_req_t;

  typedef struct packed {
    logic              stb_ack;  // strobe taken, transfer started
    logic              d_ack;    // write word taken, present the next
    logic              ack;      // beat done
    logic              err;      // beat failed, burst over
    logic [XLEN-1:0]   q;
    logic [PLEN-1:0]   adro;     // address of the returned beat
  } biu_rsp_t;

endpackage

`default_nettype wire

/* logic/line_buffer.sv */
/*
 * line buffer shared by fill and write-back bursts
 * a pending store is merged into the fill beat with its word address
 * word 0 of a write-back leaves with the strobe, the buffer holds the rest
 * beats of a fill must carry their own address on adro
 */

`timescale 1ns/1ps
`default_nettype none

module line_buffer (
  input  wire                                  clk_i,
  input  cache_biu_pkg::biu_state_e            state_i,
  input  cache_biu_pkg::biu_cmd_e              biucmd_i,
  input  cache_biu_pkg::cpu_req_t              cpu_i,
  input  wire [cache_biu_pkg::LINE_BITS-1:0]   evict_line_i,
  input  cache_biu_pkg::biu_rsp_t              rsp_i,
  output logic [cache_biu_pkg::LINE_BITS-1:0]  line_o,
  output logic                                 line_dirty_o,
  output logic [cache_biu_pkg::XLEN-1:0]       tx_word_o
);

  logic [cache_biu_pkg::LINE_BITS-1:0] line_q;
  logic                                dirty_q;
  logic                                wr_burst;  // running burst is a write-back
  logic                                adr_match; // beat is the store's word
  logic                                store_hit;
  logic [cache_biu_pkg::BEAT_BITS-1:0] slot;      // word slot of this beat
  logic [cache_biu_pkg::XLEN-1:0]      beat_q;    // beat after the store merge

  // byte lanes from new where be is set
  function automatic logic [cache_biu_pkg::XLEN-1:0] be_merge(
    input logic [cache_biu_pkg::XLEN/8-1:0] be,
    input logic [cache_biu_pkg::XLEN-1:0]   old_word,
    input logic [cache_biu_pkg::XLEN-1:0]   new_word
  );
    logic [cache_biu_pkg::XLEN-1:0] merged;
    merged = old_word;
    for (int i = 0; i < cache_biu_pkg::XLEN/8; i++)
    begin
      if (be[i])
        merged[i*8 +: 8] = new_word[i*8 +: 8];
    end
    return merged;
  endfunction

  //////////////////////////////////////////////////////////////////////
  // store merge
  assign adr_match = rsp_i.adro[cache_biu_pkg::PLEN-1:cache_biu_pkg::WORD_LSB] ==
                     cpu_i.adr[cache_biu_pkg::PLEN-1:cache_biu_pkg::WORD_LSB];
  assign store_hit = cpu_i.req & cpu_i.we & adr_match;
  assign slot      = rsp_i.adro[cache_biu_pkg::WORD_LSB +: cache_biu_pkg::BEAT_BITS];
  assign beat_q    = store_hit ? be_merge(cpu_i.be, rsp_i.q, cpu_i.d) : rsp_i.q;

  //////////////////////////////////////////////////////////////////////
  // buffer updates
  always_ff @(posedge clk_i)
  begin
    case (state_i)
      cache_biu_pkg::IDLE:
      begin
        wr_burst <= (biucmd_i == cache_biu_pkg::WRITEWAY);
        dirty_q  <= 1'b0;
        if (biucmd_i == cache_biu_pkg::WRITEWAY)
          line_q <= evict_line_i >> cache_biu_pkg::XLEN;  // word 0 goes with stb
      end
      cache_biu_pkg::BURST:
      begin
        if (!wr_burst)
        begin
          if (rsp_i.ack)
          begin
            line_q[slot*cache_biu_pkg::XLEN +: cache_biu_pkg::XLEN] <= beat_q;
            dirty_q <= dirty_q | store_hit;
          end
        end
        else if (rsp_i.d_ack)
        begin
          line_q <= line_q >> cache_biu_pkg::XLEN;        // next word to the bus
        end
      end
      default: ;                                          // WAIT4BIU holds
    endcase
  end

  //////////////////////////////////////////////////////////////////////
  // outputs
  always_comb
  begin
    line_o = line_q;
    // last beat is not registered yet when the command acks
    line_o[slot*cache_biu_pkg::XLEN +: cache_biu_pkg::XLEN] = beat_q;
  end

  assign line_dirty_o = dirty_q | store_hit;
  assign tx_word_o    = line_q[cache_biu_pkg::XLEN-1:0];

endmodule

`default_nettype wire

/* logic/transfer_counter.sv */
/*
 * burst beat counter, bus in-flight counter and flush discard counter
 * every accepted strobe adds its beats, every ack or err retires one
 * the in-flight count may not exceed 7 beats
 */

`timescale 1ns/1ps
`default_nettype none

module transfer_counter (
  input  wire                                          clk_i,
  input  wire                                          rst_ni,
  input  cache_biu_pkg::biu_state_e                    state_i,
  input  cache_biu_pkg::biu_rsp_t                      rsp_i,
  input  cache_biu_pkg::burst_type_e                   btype_i,  // type of the strobe
  input  wire                                          flush_i,
  output logic                                         last_beat_o,
  output logic [cache_biu_pkg::INFLIGHT_BITS-1:0]      inflight_cnt_o,
  output logic                                         discard_active_o
);

  logic [cache_biu_pkg::BEAT_BITS-1:0]     beat_cnt;     // beats left minus one
  logic [cache_biu_pkg::INFLIGHT_BITS-1:0] inflight_d;
  logic [cache_biu_pkg::INFLIGHT_BITS-1:0] strobe_beats; // beats of this strobe
  logic [cache_biu_pkg::INFLIGHT_BITS-1:0] discard_q;    // acks still owed after flush
  logic                                    beat_done;

  assign beat_done = rsp_i.ack | rsp_i.err;

  //////////////////////////////////////////////////////////////////////
  // beats of the running burst
  always_ff @(posedge clk_i or negedge rst_ni)
  begin
    if (!rst_ni)
      beat_cnt <= '1;
    else if (state_i == cache_biu_pkg::IDLE)
      beat_cnt <= '1;                       // wrap-4, three more after the first
    else if (state_i == cache_biu_pkg::BURST && rsp_i.ack)
      beat_cnt <= beat_cnt - 1'b1;
  end

  assign last_beat_o = ~|beat_cnt;

  //////////////////////////////////////////////////////////////////////
  // beats outstanding on the bus
  always_comb
  begin
    if (btype_i == cache_biu_pkg::WRAP4)
      strobe_beats = cache_biu_pkg::BURST_BEATS;
    else
      strobe_beats = {{(cache_biu_pkg::INFLIGHT_BITS-1){1'b0}}, 1'b1};

    inflight_d = inflight_cnt_o;
    if (rsp_i.stb_ack)
      inflight_d = inflight_d + strobe_beats;
    if (beat_done)
      inflight_d = inflight_d - 1'b1;      // strobe and ack may share a cycle
  end

  always_ff @(posedge clk_i or negedge rst_ni)
  begin
    if (!rst_ni)
      inflight_cnt_o <= '0;
    else
      inflight_cnt_o <= inflight_d;
  end

  //////////////////////////////////////////////////////////////////////
  // acks to swallow after a flush
  always_ff @(posedge clk_i or negedge rst_ni)
  begin
    if (!rst_ni)
      discard_q <= '0;
    else if (flush_i)
      discard_q <= (beat_done && |inflight_cnt_o) ? inflight_cnt_o - 1'b1
                                                  : inflight_cnt_o;
    else if (beat_done && |discard_q)
      discard_q <= discard_q - 1'b1;
  end

  assign discard_active_o = |discard_q;

endmodule

`default_nettype wire
